//--- aes_pkg.sv
package aes_pkg;

	typedef logic [127:0] block_t;
	typedef logic [255:0] key_t;
	typedef logic [127:0] round_key_t;
	typedef logic [3:0]   round_no_t;

	typedef enum logic [1:0] {
		op_key,
		op_encrypt,
		op_decrypt
	} aes_op_e;

	typedef struct packed {
		logic    valid;
		aes_op_e op;
		logic    aes256;
	} aes_cmd_t;

	localparam round_no_t nr_128 = 4'd10;
	localparam round_no_t nr_256 = 4'd14;

	function automatic logic [7:0] xtime(logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
		logic [7:0] p;
		logic [7:0] aa;
		p = 8'h00;
		aa = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ aa;
			aa = xtime(aa);
		end
		return p;
	endfunction

	// a^254 by square and multiply, zero maps to zero
	function automatic logic [7:0] gf_inv(logic [7:0] a);
		logic [7:0] p;
		logic [7:0] r;
		p = a;
		r = 8'h01;
		for (int i = 0; i < 7; i++) begin
			p = gf_mul(p, p);
			r = gf_mul(r, p);
		end
		return r;
	endfunction

	function automatic logic [7:0] rotl(logic [7:0] b, int n);
		return (b << n) | (b >> (8 - n));
	endfunction

	function automatic logic [7:0] sub_byte(logic [7:0] b);
		logic [7:0] v;
		v = gf_inv(b);
		return v ^ rotl(v, 1) ^ rotl(v, 2) ^ rotl(v, 3) ^ rotl(v, 4) ^ 8'h63;
	endfunction

	// undo the affine map first, then invert
	function automatic logic [7:0] inv_sub_byte(logic [7:0] b);
		return gf_inv(rotl(b, 1) ^ rotl(b, 3) ^ rotl(b, 6) ^ 8'h05);
	endfunction

	function automatic logic [31:0] sub_word(logic [31:0] w);
		return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
	endfunction

	function automatic logic [31:0] mix_column(logic [31:0] c);
		logic [7:0] a0, a1, a2, a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	function automatic logic [31:0] inv_mix_column(logic [31:0] c);
		logic [7:0] a0, a1, a2, a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
			gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
			gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
			gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
	endfunction

	// byte r + 4c sits at bits 127-8(r+4c) down, column-major as in FIPS-197
	function automatic block_t shift_rows(block_t s);
		block_t o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[127 - 8 * (r + 4 * c) -: 8] = s[127 - 8 * (r + 4 * ((c + r) % 4)) -: 8];
		return o;
	endfunction

	function automatic block_t inv_shift_rows(block_t s);
		block_t o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[127 - 8 * (r + 4 * ((c + r) % 4)) -: 8] = s[127 - 8 * (r + 4 * c) -: 8];
		return o;
	endfunction

	function automatic block_t sub_bytes(block_t s);
		block_t o;
		for (int i = 0; i < 16; i++)
			o[8 * i +: 8] = sub_byte(s[8 * i +: 8]);
		return o;
	endfunction

	function automatic block_t inv_sub_bytes(block_t s);
		block_t o;
		for (int i = 0; i < 16; i++)
			o[8 * i +: 8] = inv_sub_byte(s[8 * i +: 8]);
		return o;
	endfunction

	function automatic block_t mix_columns(block_t s);
		block_t o;
		for (int c = 0; c < 4; c++)
			o[32 * c +: 32] = mix_column(s[32 * c +: 32]);
		return o;
	endfunction

	function automatic block_t inv_mix_columns(block_t s);
		block_t o;
		for (int c = 0; c < 4; c++)
			o[32 * c +: 32] = inv_mix_column(s[32 * c +: 32]);
		return o;
	endfunction

endpackage

//--- key_ram.sv
module key_ram (
	input  logic                   clk,
	input  logic                   w_e,
	input  aes_pkg::round_no_t     w_addr,
	input  aes_pkg::round_key_t    w_data,
	input  aes_pkg::round_no_t     r_addr,
	output aes_pkg::round_key_t    r_data
);
	import aes_pkg::*;

	round_key_t mem [16];

	always_ff @(posedge clk) begin
		if (w_e)
			mem[w_addr] <= w_data;
	end

	// read is combinational so a cipher unit gets its key in the same cycle
	assign r_data = mem[r_addr];

endmodule

//--- key_expand.sv
module key_expand (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   aes256,
	input  aes_pkg::round_no_t     rounds_total,
	input  aes_pkg::key_t          key,
	output logic                   w_e,
	output aes_pkg::round_no_t     w_addr,
	output aes_pkg::round_key_t    w_data,
	output logic                   done
);
	import aes_pkg::*;

	typedef enum logic {idle, run} state_e;

	state_e     fsm;
	round_no_t  cnt;
	key_t       win;
	logic       key256;
	logic       sub_step;
	logic [7:0] rcon;
	logic       use_rcon;
	logic [31:0] last_word;
	logic [31:0] t;
	logic [127:0] nxt;

	// 256-bit keys alternate rcon and plain sub_word steps
	assign use_rcon = !key256 || !sub_step;
	assign last_word = key256 ? win[31:0] : win[159:128];

	always_comb begin
		if (use_rcon)
			t = sub_word({last_word[23:0], last_word[31:24]}) ^ {rcon, 24'h0};
		else
			t = sub_word(last_word);
		nxt[127:96] = win[255:224] ^ t;
		nxt[95:64] = win[223:192] ^ nxt[127:96];
		nxt[63:32] = win[191:160] ^ nxt[95:64];
		nxt[31:0] = win[159:128] ^ nxt[63:32];
	end

	assign w_e = (fsm == run);
	assign w_addr = cnt;
	assign w_data = win[255:128];

	always_ff @(posedge clk) begin
		if (reset) begin
			fsm <= idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (fsm == idle) begin
				if (start) begin
					fsm <= run;
					cnt <= '0;
				end
			end else if (cnt == rounds_total) begin
				fsm <= idle;
				done <= 1'b1;
			end else begin
				cnt <= cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fsm == idle) begin
			win <= key;
			key256 <= aes256;
			rcon <= 8'h01;
			sub_step <= 1'b0;
		end else begin
			win <= key256 ? {win[127:0], nxt} : {nxt, nxt};
			sub_step <= !sub_step;
			if (use_rcon)
				rcon <= xtime(rcon);
		end
	end

endmodule

//--- aes_encrypt.sv
module aes_encrypt (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  aes_pkg::round_no_t     rounds_total,
	input  aes_pkg::block_t        blk_in,
	input  aes_pkg::round_key_t    round_key,
	output aes_pkg::round_no_t     round_no,
	output aes_pkg::block_t        blk_out,
	output logic                   done
);
	import aes_pkg::*;

	typedef enum logic {idle, run} state_e;

	state_e    fsm;
	round_no_t cnt;
	block_t    state_reg;
	block_t    shifted;
	block_t    next_state;

	always_comb begin
		shifted = shift_rows(sub_bytes(state_reg));
		// final round has no mix_columns
		if (cnt == rounds_total)
			next_state = shifted ^ round_key;
		else
			next_state = mix_columns(shifted) ^ round_key;
	end

	assign round_no = (fsm == run) ? cnt : '0;
	assign blk_out = state_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			fsm <= idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (fsm == idle) begin
				if (start) begin
					fsm <= run;
					cnt <= 4'd1;
				end
			end else if (cnt == rounds_total) begin
				fsm <= idle;
				cnt <= '0;
				done <= 1'b1;
			end else begin
				cnt <= cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fsm == idle && start)
			state_reg <= blk_in ^ round_key;
		else if (fsm == run)
			state_reg <= next_state;
	end

endmodule

//--- aes_decrypt.sv
module aes_decrypt (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  aes_pkg::round_no_t     rounds_total,
	input  aes_pkg::block_t        blk_in,
	input  aes_pkg::round_key_t    round_key,
	output aes_pkg::round_no_t     round_no,
	output aes_pkg::block_t        blk_out,
	output logic                   done
);
	import aes_pkg::*;

	typedef enum logic {idle, run} state_e;

	state_e    fsm;
	round_no_t cnt;
	block_t    state_reg;
	block_t    keyed;
	block_t    next_state;

	// inverse round in straight order, so the normal key schedule is reused
	always_comb begin
		keyed = inv_sub_bytes(inv_shift_rows(state_reg)) ^ round_key;
		if (cnt == '0)
			next_state = keyed;
		else
			next_state = inv_mix_columns(keyed);
	end

	// while idle the last round key is presented for the initial add
	assign round_no = (fsm == run) ? cnt : rounds_total;
	assign blk_out = state_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			fsm <= idle;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (fsm == idle) begin
				if (start) begin
					fsm <= run;
					cnt <= rounds_total - 4'd1;
				end
			end else if (cnt == '0) begin
				fsm <= idle;
				done <= 1'b1;
			end else begin
				cnt <= cnt - 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fsm == idle && start)
			state_reg <= blk_in ^ round_key;
		else if (fsm == run)
			state_reg <= next_state;
	end

endmodule

//--- aes_top.sv
module aes_top (
	input  logic               clk,
	input  logic               reset,
	input  aes_pkg::aes_cmd_t  cmd,
	input  aes_pkg::key_t      key,
	input  aes_pkg::block_t    blk_in,
	output aes_pkg::block_t    blk_out,
	output logic               busy,
	output logic               done
);
	import aes_pkg::*;

	logic       accept;
	logic       key_start;
	logic       enc_start;
	logic       dec_start;
	aes_op_e    active_op;
	logic       key256;
	round_no_t  rounds_total;
	round_no_t  mem_addr;
	round_no_t  kg_addr;
	round_no_t  enc_round_no;
	round_no_t  dec_round_no;
	round_key_t kg_data;
	round_key_t mem_rdata;
	logic       kg_we;
	logic       kg_done;
	logic       enc_done;
	logic       dec_done;
	block_t     enc_out;
	block_t     dec_out;

	assign accept = cmd.valid && !busy;
	assign key_start = accept && (cmd.op == op_key);
	assign enc_start = accept && (cmd.op == op_encrypt);
	assign dec_start = accept && (cmd.op == op_decrypt);

	// key size comes from the last key load, not from the block command
	assign rounds_total = key256 ? nr_256 : nr_128;
	assign done = kg_done | enc_done | dec_done;

	// cipher units read their first key in the start cycle, before busy is up
	always_comb begin
		if (busy && active_op == op_key)
			mem_addr = kg_addr;
		else if (enc_start || (busy && active_op == op_encrypt))
			mem_addr = enc_round_no;
		else if (dec_start || (busy && active_op == op_decrypt))
			mem_addr = dec_round_no;
		else
			mem_addr = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			active_op <= op_key;
			key256 <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				active_op <= cmd.op;
			end else if (done) begin
				busy <= 1'b0;
			end
			if (key_start)
				key256 <= cmd.aes256;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			blk_out <= '0;
		else if (enc_done)
			blk_out <= enc_out;
		else if (dec_done)
			blk_out <= dec_out;
	end

	key_ram key_mem (
		.clk(clk),
		.w_e(kg_we),
		.w_addr(mem_addr),
		.w_data(kg_data),
		.r_addr(mem_addr),
		.r_data(mem_rdata)
	);

	key_expand key_gen (
		.clk(clk),
		.reset(reset),
		.start(key_start),
		.aes256(cmd.aes256),
		.rounds_total(rounds_total),
		.key(key),
		.w_e(kg_we),
		.w_addr(kg_addr),
		.w_data(kg_data),
		.done(kg_done)
	);

	aes_encrypt encrypt_blk (
		.clk(clk),
		.reset(reset),
		.start(enc_start),
		.rounds_total(rounds_total),
		.blk_in(blk_in),
		.round_key(mem_rdata),
		.round_no(enc_round_no),
		.blk_out(enc_out),
		.done(enc_done)
	);

	aes_decrypt decrypt_blk (
		.clk(clk),
		.reset(reset),
		.start(dec_start),
		.rounds_total(rounds_total),
		.blk_in(blk_in),
		.round_key(mem_rdata),
		.round_no(dec_round_no),
		.blk_out(dec_out),
		.done(dec_done)
	);

endmodule

//--- tb_aes.sv
module tb_aes;
	import aes_pkg::*;

	localparam int clk_period = 100;
	localparam int trips_per_size = 4;
	// three vector ops, two for the dropped pair, three more vectors, trips, four closing ops
	localparam int test_ops = 3 + 2 + 3 + 2 * 3 * trips_per_size + 4;

	localparam key_t fips_key_128 = {128'h000102030405060708090a0b0c0d0e0f, 128'h0};
	localparam key_t fips_key_256 =
		256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
	localparam block_t fips_pt = 128'h00112233445566778899aabbccddeeff;
	localparam block_t fips_ct_128 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam block_t fips_ct_256 = 128'h8ea2b7ca516745bfeafc49904b496089;

	logic     clk;
	logic     reset;
	aes_cmd_t cmd;
	key_t     key;
	block_t   blk_in;
	block_t   blk_out;
	logic     busy;
	logic     done;

	int     errors = 0;
	int     seed = 32'h89ce_2a30;
	block_t expected = '0;
	logic   check_blk = 1'b1;
	logic   loaded_256 = 1'b0;
	block_t last_out;

	aes_top i_aes_top (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.key(key),
		.blk_in(blk_in),
		.blk_out(blk_out),
		.busy(busy),
		.done(done)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	reset_check: assert property (@(posedge clk) reset |=> (!busy && !done && blk_out == '0))
		else begin
			errors++;
			$display("** Error: after reset busy = %h, done = %h, blk_out = %h, expected all 0",
				$sampled(busy), $sampled(done), $sampled(blk_out));
		end

	busy_rise: assert property (@(posedge clk) disable iff (reset) (cmd.valid && !busy) |=> busy)
		else begin
			errors++;
			$display("** Error: busy = %h after accepted command, expected 1", $sampled(busy));
		end

	busy_fall: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
		else begin
			errors++;
			$display("** Error: busy = %h after done, expected 0", $sampled(busy));
		end

	// key loads keep check_blk set to prove blk_out is held
	blk_out_check: assert property (@(posedge clk) disable iff (reset)
		(done && check_blk) |=> (blk_out == expected))
		else begin
			errors++;
			$display("** Error: blk_out = %h, expected %h", $sampled(blk_out), $sampled(expected));
		end

	function automatic block_t rand_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic issue_op(input aes_op_e op, input logic size256, input key_t k,
		input block_t b, input logic chk, input block_t exp);
		int cycles;
		int exp_cycles;
		@(posedge clk);
		cmd.valid <= 1'b1;
		cmd.op <= op;
		cmd.aes256 <= size256;
		key <= k;
		blk_in <= b;
		if (op == op_key) begin
			check_blk <= 1'b1;
			loaded_256 = size256;
		end else begin
			check_blk <= chk;
			expected <= exp;
		end
		@(posedge clk);
		cmd.valid <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!done) begin
			cycles++;
			@(negedge clk);
		end
		exp_cycles = (loaded_256 ? 14 : 10) + ((op == op_key) ? 1 : 0);
		assert (cycles == exp_cycles)
			else begin
				errors++;
				$display("** Error: cycles to done = %h, expected %h", cycles, exp_cycles);
			end
		@(posedge clk);
		@(negedge clk);
		last_out = blk_out;
		@(posedge clk);
	endtask

	// a decrypt sent while the encrypt runs must be dropped
	task automatic drop_check(input block_t b, input block_t exp);
		int dones;
		@(posedge clk);
		cmd.valid <= 1'b1;
		cmd.op <= op_encrypt;
		blk_in <= b;
		check_blk <= 1'b1;
		expected <= exp;
		@(posedge clk);
		cmd.op <= op_decrypt;
		blk_in <= ~b;
		@(posedge clk);
		cmd.valid <= 1'b0;
		dones = 0;
		repeat (40) begin
			@(negedge clk);
			if (done)
				dones++;
		end
		assert (dones == 1)
			else begin
				errors++;
				$display("** Error: done pulses = %h, expected %h", dones, 1);
			end
		repeat (2) @(posedge clk);
	endtask

	task automatic round_trip(input logic size256);
		key_t   k;
		block_t pt;
		block_t ct;
		k = {rand_block(), rand_block()};
		pt = rand_block();
		issue_op(op_key, size256, k, '0, 1'b1, '0);
		issue_op(op_encrypt, 1'b0, '0, pt, 1'b0, '0);
		ct = last_out;
		issue_op(op_decrypt, 1'b0, '0, ct, 1'b1, pt);
	endtask

	initial begin
		reset = 1'b1;
		cmd = '0;
		key = '0;
		blk_in = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		issue_op(op_key, 1'b0, fips_key_128, '0, 1'b1, '0);
		issue_op(op_encrypt, 1'b0, '0, fips_pt, 1'b1, fips_ct_128);
		issue_op(op_decrypt, 1'b0, '0, fips_ct_128, 1'b1, fips_pt);

		drop_check(fips_pt, fips_ct_128);

		issue_op(op_key, 1'b1, fips_key_256, '0, 1'b1, '0);
		issue_op(op_encrypt, 1'b0, '0, fips_pt, 1'b1, fips_ct_256);
		issue_op(op_decrypt, 1'b0, '0, fips_ct_256, 1'b1, fips_pt);

		for (int i = 0; i < trips_per_size; i++) begin
			round_trip(1'b0);
			round_trip(1'b1);
		end

		// each encrypt carries the opposite aes256 bit from the loaded key
		issue_op(op_key, 1'b0, fips_key_128, '0, 1'b1, '0);
		issue_op(op_encrypt, 1'b1, '0, fips_pt, 1'b1, fips_ct_128);
		issue_op(op_key, 1'b1, fips_key_256, '0, 1'b1, '0);
		issue_op(op_encrypt, 1'b0, '0, fips_pt, 1'b1, fips_ct_256);

		repeat (2) @(posedge clk);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(test_ops * 200 * clk_period);
		$display("timeout: the operations did not finish in the time allowed");
		$display("errors: %0d", errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
aes_pkg.sv
key_ram.sv
key_expand.sv
aes_encrypt.sv
aes_decrypt.sv
aes_top.sv
tb_aes.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_aes
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
